//--- hw/reduce_pkg.sv
package reduce_pkg;

  localparam int SAMPLE_WIDTH = 16;  // Bits per fixed-point sample
  localparam int NUM_LANES    = 4;   // Samples per group

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  localparam sample_t SAT_MAX = 16'sh7fff;  // Largest positive sample
  localparam sample_t SAT_MIN = 16'sh8000;  // Most negative sample

  // Word addresses on the bus
  localparam logic [2:0] ADR_LANES_LO = 3'd0;  // Lanes 0 and 1
  localparam logic [2:0] ADR_LANES_HI = 3'd1;  // Lanes 2 and 3, launches the group
  localparam logic [2:0] ADR_FLUSH    = 3'd2;  // Push accumulator to queue
  localparam logic [2:0] ADR_RESULT   = 3'd3;  // Pop queue head
  localparam logic [2:0] ADR_STATUS   = 3'd4;  // Count and busy

  localparam int QUEUE_DEPTH = 4;
  localparam int COUNT_WIDTH = 3;  // Holds 0 to QUEUE_DEPTH

  // Signed add clamped to the sample range
  function automatic sample_t sat_add(input sample_t a, input sample_t b);
    logic [SAMPLE_WIDTH:0] wide;
    sample_t               res;
    wide = {a[SAMPLE_WIDTH-1], a} + {b[SAMPLE_WIDTH-1], b};  // Sign-extended sum
    if (wide[SAMPLE_WIDTH] != wide[SAMPLE_WIDTH-1]) begin
      // Carry-out sign decides direction of overflow
      res = wide[SAMPLE_WIDTH] ? SAT_MIN : SAT_MAX;
    end else begin
      res = sample_t'(wide[SAMPLE_WIDTH-1:0]);
    end
    return res;
  endfunction

endpackage

//--- hw/reduce_if.sv
`timescale 1ns/10ps

// Link between bus port and adder tree
interface reduce_if;

  logic                launch;                          // One-cycle group start
  reduce_pkg::sample_t lanes [reduce_pkg::NUM_LANES];   // Operands of current group
  logic                flush;                           // Held until flush_done
  logic                flush_done;                      // Accumulator pushed
  logic                busy;                            // Groups still in flight

  modport port (
    output launch,
    output lanes,
    output flush,
    input  flush_done,
    input  busy
  );

  modport tree (
    input  launch,
    input  lanes,
    input  flush,
    output flush_done,
    output busy
  );

endinterface

//--- hw/wb_reduce_port.sv
`timescale 1ns/10ps

module wb_reduce_port (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 wb_cyc,
  input  logic                                 wb_stb,
  input  logic                                 wb_we,
  input  logic [2:0]                           wb_adr,
  input  logic [31:0]                          wb_dat_w,
  output logic [31:0]                          wb_dat_r,
  output logic                                 wb_ack,
  reduce_if.port                               tree_bus,
  output logic                                 pop,
  input  reduce_pkg::sample_t                  head,
  input  logic [reduce_pkg::COUNT_WIDTH-1:0]   count
);

  logic        req;          // New classic cycle
  logic        wr_lo;
  logic        wr_hi;
  logic        wr_flush;
  logic        rd_result;
  logic        queue_valid;  // Queue holds a result
  logic [31:0] read_word;

  assign req         = wb_cyc & wb_stb & ~wb_ack;  // Ack cycle is not a new request
  assign wr_lo       = req & wb_we & (wb_adr == reduce_pkg::ADR_LANES_LO);
  assign wr_hi       = req & wb_we & (wb_adr == reduce_pkg::ADR_LANES_HI);
  assign wr_flush    = req & wb_we & (wb_adr == reduce_pkg::ADR_FLUSH);
  assign rd_result   = req & ~wb_we & (wb_adr == reduce_pkg::ADR_RESULT);
  assign queue_valid = (count != '0);

  // Read mux
  always_comb begin
    read_word = '0;  // Unmapped reads return zero
    case (wb_adr)
      reduce_pkg::ADR_RESULT: begin
        if (queue_valid) begin
          read_word[31]   = 1'b1;  // Valid flag
          read_word[15:0] = head;
        end
      end
      reduce_pkg::ADR_STATUS: begin
        read_word[reduce_pkg::COUNT_WIDTH-1:0] = count;
        read_word[8] = tree_bus.busy;
      end
      default: read_word = '0;
    endcase
  end

  // Handshake and command state
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack         <= 1'b0;
      tree_bus.launch <= 1'b0;
      tree_bus.flush  <= 1'b0;
      pop            <= 1'b0;
    end else begin
      wb_ack          <= 1'b0;  // Single-cycle pulses by default
      tree_bus.launch <= 1'b0;
      pop             <= 1'b0;
      if (tree_bus.flush) begin
        // Flush in progress, ack follows completion
        if (tree_bus.flush_done) begin
          tree_bus.flush <= 1'b0;
          wb_ack         <= 1'b1;
        end
      end else if (req) begin
        if (wr_flush) begin
          tree_bus.flush <= 1'b1;  // Ack withheld
        end else begin
          wb_ack          <= 1'b1;
          tree_bus.launch <= wr_hi;                    // Coincides with ack
          pop             <= rd_result & queue_valid;  // Empty queue not popped
        end
      end
    end
  end

  // Lane registers and read data
  always_ff @(posedge clk) begin
    if (wr_lo) begin
      tree_bus.lanes[0] <= wb_dat_w[15:0];
      tree_bus.lanes[1] <= wb_dat_w[31:16];
    end
    if (wr_hi) begin
      tree_bus.lanes[2] <= wb_dat_w[15:0];
      tree_bus.lanes[3] <= wb_dat_w[31:16];
    end
    if (req & ~wb_we) wb_dat_r <= read_word;  // Held through ack cycle
  end

endmodule

//--- hw/staged_adder_tree.sv
`timescale 1ns/10ps

module staged_adder_tree (
  input  logic                clk,
  input  logic                reset,
  reduce_if.tree              tree_bus,
  output logic                push,
  output reduce_pkg::sample_t push_data,
  input  logic                full
);

  logic                stage2_run;  // Pair sums load
  logic                stage1_run;  // Group sum loads
  logic                stage0_run;  // Accumulator loads
  reduce_pkg::sample_t pair0_sum;   // Lanes 0 and 1
  reduce_pkg::sample_t pair1_sum;   // Lanes 2 and 3
  reduce_pkg::sample_t group_sum;
  reduce_pkg::sample_t acc;
  logic                pipe_empty;
  logic                flush_go;

  assign stage2_run = tree_bus.launch;

  // Run enables shift with the group through the tree
  always_ff @(posedge clk) begin
    if (reset) begin
      stage1_run <= 1'b0;
      stage0_run <= 1'b0;
    end else begin
      stage1_run <= stage2_run;
      stage0_run <= stage1_run;
    end
  end

  // Stage 2, captured on the edge ending launch
  always_ff @(posedge clk) begin
    if (stage2_run) begin
      pair0_sum <= reduce_pkg::sat_add(tree_bus.lanes[0], tree_bus.lanes[1]);
      pair1_sum <= reduce_pkg::sat_add(tree_bus.lanes[2], tree_bus.lanes[3]);
    end
  end

  // Stage 1
  always_ff @(posedge clk) begin
    if (stage1_run) group_sum <= reduce_pkg::sat_add(pair0_sum, pair1_sum);
  end

  // Stage 0 folds groups into the running sum
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (flush_go) begin
      acc <= '0;  // Pushed value leaves, start over
    end else if (stage0_run) begin
      acc <= reduce_pkg::sat_add(acc, group_sum);
    end
  end

  // Flush waits for the tree to drain and for queue room
  assign pipe_empty = ~(stage2_run | stage1_run | stage0_run);
  assign flush_go   = tree_bus.flush & pipe_empty & ~full;

  assign tree_bus.flush_done = flush_go;
  assign tree_bus.busy       = stage1_run | stage0_run;
  assign push                = flush_go;  // Same cycle as flush_done
  assign push_data           = acc;

endmodule

//--- hw/result_queue.sv
`timescale 1ns/10ps

module result_queue (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               push,
  input  reduce_pkg::sample_t                push_data,
  output logic                               full,
  input  logic                               pop,
  output reduce_pkg::sample_t                head,
  output logic [reduce_pkg::COUNT_WIDTH-1:0] count
);

  reduce_pkg::sample_t                 mem [reduce_pkg::QUEUE_DEPTH];
  logic [reduce_pkg::COUNT_WIDTH-2:0]  wr_ptr;  // Wraps at power-of-two depth
  logic [reduce_pkg::COUNT_WIDTH-2:0]  rd_ptr;
  logic                                do_push;
  logic                                do_pop;

  assign full    = (count == reduce_pkg::COUNT_WIDTH'(reduce_pkg::QUEUE_DEPTH));
  assign do_push = push & ~full;
  assign do_pop  = pop & (count != '0);  // Pop of empty queue dropped
  assign head    = mem[rd_ptr];          // Oldest entry

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither, level unchanged
      endcase
    end
  end

endmodule

//--- hw/dot_reduce_top.sv
`timescale 1ns/10ps

module dot_reduce_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [2:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack
);

  logic                               pop;
  logic                               push;
  logic                               full;
  reduce_pkg::sample_t                head;
  reduce_pkg::sample_t                push_data;
  logic [reduce_pkg::COUNT_WIDTH-1:0] count;

  reduce_if tree_bus ();

  // Bus side
  wb_reduce_port wb_reduce_port_i (
    .clk, .reset,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .tree_bus (tree_bus.port),
    .pop, .head, .count
  );

  staged_adder_tree staged_adder_tree_i (
    .clk, .reset,
    .tree_bus (tree_bus.tree),
    .push, .push_data, .full
  );

  // Finished sums wait here for the host
  result_queue result_queue_i (
    .clk, .reset,
    .push, .push_data, .full,
    .pop, .head, .count
  );

endmodule

//--- bench/dot_reduce_checker.sv
`timescale 1ns/10ps

// Protocol properties on the bus, the tree and the queue
module dot_reduce_checker (
  input logic clk,
  input logic reset,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic push,
  input logic full,
  input logic launch,
  input logic flush_done
);

  // Ack only inside an active classic cycle
  ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> (wb_cyc && wb_stb))
    else $error("wb_ack high without wb_cyc and wb_stb");

  ack_single: assert property (@(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack)
    else $error("wb_ack high on two consecutive cycles");

  push_not_full: assert property (@(posedge clk) disable iff (reset)
    $rose(push) |-> !full)
    else $error("push rose while the result queue was full");

  // Flush waits for an empty tree, launch included
  launch_flush_apart: assert property (@(posedge clk) disable iff (reset)
    !(launch && flush_done))
    else $error("launch and flush_done in the same cycle");

endmodule

//--- bench/dot_reduce_tb.sv
`timescale 1ns/10ps

module dot_reduce_tb;

  typedef enum logic [2:0] {OP_GROUP, OP_FLUSH, OP_RESULT, OP_STATUS, OP_STALL} op_t;

  logic        clk = 1'b0;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  op_t                op_tab[$];         // Stimulus table, one entry per row
  logic [63:0]        lane_tab[$];       // Lane 3 down to lane 0
  logic [31:0]        exp_tab[$];        // Expected read word
  logic signed [15:0] acc_m = '0;        // Model accumulator
  logic [15:0]        queue_m[$];        // Model result queue
  logic               after_group = 1'b0;
  int                 cycle_limit = 0;

  always #2 clk = ~clk;  // 4 ns period

  dot_reduce_top dot_reduce_top_i (
    .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
  );

  bind dot_reduce_top dot_reduce_checker dot_reduce_checker_i (
    .clk, .reset, .wb_cyc, .wb_stb, .wb_ack, .push, .full,
    .launch (tree_bus.launch), .flush_done (tree_bus.flush_done)
  );

  // Saturating add from integer range limits
  function automatic logic signed [15:0] model_add(input logic signed [15:0] a,
                                                   input logic signed [15:0] b);
    int s;
    s = int'(a) + int'(b);
    if (s > 32767) return 16'sh7fff;
    if (s < -32768) return 16'sh8000;
    return 16'(s);
  endfunction

  function automatic logic signed [15:0] rand_sample();
    logic signed [15:0] v;
    v = 16'($urandom);
    return v >>> 2;  // Quarter range, so only some groups clamp
  endfunction

  task automatic add_row(input op_t op, input logic [63:0] lanes, input logic [31:0] exp_word);
    op_tab.push_back(op);
    lane_tab.push_back(lanes);
    exp_tab.push_back(exp_word);
    after_group = (op == OP_GROUP);  // Status right after a launch sees busy
  endtask

  // Tree order: pairs 0+1 and 2+3, then pair sums, then accumulator
  task automatic add_group(input logic signed [15:0] l0, l1, l2, l3);
    acc_m = model_add(acc_m, model_add(model_add(l0, l1), model_add(l2, l3)));
    add_row(OP_GROUP, {l3, l2, l1, l0}, 32'd0);
  endtask

  task automatic add_flush();
    queue_m.push_back(acc_m);
    acc_m = '0;
    add_row(OP_FLUSH, '0, 32'd0);
  endtask

  task automatic add_result();
    if (queue_m.size() > 0) add_row(OP_RESULT, '0, {1'b1, 15'd0, queue_m.pop_front()});
    else add_row(OP_RESULT, '0, 32'd0);  // Empty queue reads as invalid zero
  endtask

  task automatic add_status();
    add_row(OP_STATUS, '0, {23'd0, after_group, 5'd0, 3'(queue_m.size())});
  endtask

  // Full queue keeps the port in its flush state until reset
  task automatic add_stall();
    queue_m.delete();
    acc_m = '0;
    add_row(OP_STALL, '0, 32'd0);
  endtask

  task automatic build_table();
    add_group(16'sd100, 16'sd200, -16'sd50, 16'sd7);  // Single group
    add_flush();
    add_result();
    add_group(16'sd1000, -16'sd3, 16'sd12, 16'sd400);  // Back-to-back groups
    add_group(-16'sd2500, 16'sd77, 16'sd0, 16'sd9);
    add_group(16'sd31, 16'sd32, 16'sd33, -16'sd34);
    add_flush();
    add_result();
    add_flush();  // Cleared accumulator gives 0
    add_result();
    add_group(16'sh7000, 16'sh7000, -16'sh1000, 16'sd0);  // Pair clamps high
    add_flush();
    add_result();
    add_group(16'sh4000, 16'sh3000, 16'sh4000, 16'sh3000);  // Group clamps high
    add_group(16'sd1, 16'sd0, 16'sd0, 16'sd0);  // Accumulator clamps high
    add_flush();
    add_result();
    add_group(16'sh8000, -16'sd1, 16'sd1, 16'sd0);  // Pair clamps low
    add_flush();
    add_result();
    add_group(-16'sh5000, -16'sh5000, -16'sh6000, 16'sd0);  // Group clamps low
    add_flush();
    add_result();
    add_result();  // Empty queue
    add_group(16'sd5, 16'sd6, 16'sd7, 16'sd8);
    add_status();  // Busy while in flight
    add_flush();
    add_status();
    add_result();
    for (int i = 0; i < 4; i++) begin
      add_group(16'(i * 111), 16'sd3, -16'sd20, 16'(i));
      add_flush();
    end
    add_status();  // Count 4
    add_result();
    add_group(16'sd9, 16'sd9, 16'sd9, 16'sd9);
    add_flush();
    repeat (4) add_result();  // FIFO order
    repeat (4) add_flush();
    add_stall();
    add_status();
    for (int i = 0; i < 8; i++) begin
      add_group(rand_sample(), rand_sample(), rand_sample(), rand_sample());
      if (i % 2 == 1) begin
        add_flush();
        add_result();
      end
    end
  endtask

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped on a failed check");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp_word,
                            input logic [31:0] actual);
    assert (actual === exp_word)
      else stop_run($sformatf("Error at %0t: %s expected %h, actual %h",
                              $time, name, exp_word, actual));
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
  endtask

  // Classic cycle, stb held through the ack cycle
  task automatic bus_cycle(input logic we, input logic [2:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdat);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    do begin
      @(posedge clk);
      #1;
    end while (!wb_ack);
    rdat = wb_dat_r;
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic expect_stall();
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = reduce_pkg::ADR_FLUSH;
    wb_dat_w = '0;
    repeat (20) begin
      @(posedge clk);
      #1;
      assert (!wb_ack) else stop_run("Flush was acknowledged while the result queue was full");
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    apply_reset();  // Only way out of a stalled flush
  endtask

  task automatic run_row(input op_t op, input logic [63:0] lanes, input logic [31:0] exp_word);
    logic [31:0] rdata;
    case (op)
      OP_GROUP: begin
        bus_cycle(1'b1, reduce_pkg::ADR_LANES_LO, lanes[31:0], rdata);
        bus_cycle(1'b1, reduce_pkg::ADR_LANES_HI, lanes[63:32], rdata);  // Launches
      end
      OP_FLUSH: bus_cycle(1'b1, reduce_pkg::ADR_FLUSH, 32'd0, rdata);
      OP_RESULT: begin
        bus_cycle(1'b0, reduce_pkg::ADR_RESULT, 32'd0, rdata);
        check_word("wb_dat_r (result)", exp_word, rdata);
      end
      OP_STATUS: begin
        bus_cycle(1'b0, reduce_pkg::ADR_STATUS, 32'd0, rdata);
        check_word("wb_dat_r (status)", exp_word, rdata);
      end
      OP_STALL: expect_stall();
      default: ;
    endcase
  endtask

  initial begin : stimulus
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    void'($urandom(49420));
    build_table();
    cycle_limit = 40 * op_tab.size() + 100;
    apply_reset();
    foreach (op_tab[i]) run_row(op_tab[i], lane_tab[i], exp_tab[i]);
    $display("Finished with no errors");
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the DUT stopped answering the bus", cycles);
    $display("Finished with errors");
    $fatal(1, "Timeout");
  end

endmodule

//--- dot_reduce.f
hw/reduce_pkg.sv
hw/reduce_if.sv
hw/wb_reduce_port.sv
hw/staged_adder_tree.sv
hw/result_queue.sv
hw/dot_reduce_top.sv
bench/dot_reduce_checker.sv
bench/dot_reduce_tb.sv

//--- Makefile
# Verilator simulation of the reduction engine

VERILATOR ?= verilator
TOP       ?= dot_reduce_tb
FILELIST  ?= dot_reduce.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Exit status of the simulation binary is the pass or fail result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)
